// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module tbEvbReadout -f tb.f -Mdir obj_dir -o simv \
	&& ./obj_dir/simv | tee sim.log \
	|| echo "Build or simulation did not complete"
grep -qx "Result: PASSED" sim.log 2>/dev/null && echo "Simulation passed" && exit 0 \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// ==== source/blockTracker.sv ====
// Block tracker, counts complete event blocks held in the output FIFO
`timescale 1ns/1ps

module blockTracker
	import evbFormatPkg::*, outWordPkg::*;
#(
	parameter int BlockCountWidth = 8
)
(
	input  logic                       CLK,
	input  logic                       RSTb,
	input  logic                       clear,
	input  logic                       write,
	input  outWord_t                   writeWord,
	input  logic                       read,
	input  outWord_t                   headWord,
	output logic [BlockCountWidth-1:0] blockCount
);

	localparam logic [BlockCountWidth-1:0] MaxCount = '1;

	logic writeEob;
	logic readEob;
	logic incReq;
	logic decReq;

	// Block end is flagged by the lower event only
	assign writeEob = write && (writeWord.lowerEvent.fields.tag == EndOfBlockTag);
	assign readEob = read && (headWord.lowerEvent.fields.tag == EndOfBlockTag);

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (RSTb == 1'b0)
		begin
			incReq <= 1'b0;
			decReq <= 1'b0;
		end
		else if (clear)
		begin
			incReq <= 1'b0;
			decReq <= 1'b0;
		end
		else
		begin
			incReq <= writeEob && !readEob;	// Simultaneous ends cancel out
			decReq <= readEob && !writeEob;
		end
	end

	// Saturating block counter
	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (RSTb == 1'b0)
			blockCount <= '0;
		else if (clear)
			blockCount <= '0;
		else if (incReq && blockCount != MaxCount)
			blockCount <= blockCount + 1'b1;
		else if (decReq && blockCount != '0)
			blockCount <= blockCount - 1'b1;
	end

endmodule

// ==== source/evbFormatPkg.sv ====
// Event builder format package, 24-bit event word with tag and payload views
package evbFormatPkg;

	localparam int EventWidth = 24;
	localparam int TagWidth = 4;
	localparam int PayloadWidth = EventWidth - TagWidth;

	// Tag of the last event in a block
	localparam logic [TagWidth-1:0] EndOfBlockTag = 4'b0010;

	// Tag sits in the top nibble of the event
	typedef struct packed
	{
		logic [TagWidth-1:0] tag;
		logic [PayloadWidth-1:0] payload;
	} eventFields_t;

	// Raw view moves data, field view feeds block detection
	typedef union packed
	{
		logic [EventWidth-1:0] raw;
		eventFields_t fields;
	} eventWord_u;

endpackage

// ==== source/evbReadout.sv ====
// Event buffer readout top, bypass path from event builder to user and fiber ports
`timescale 1ns/1ps

module evbReadout
	import evbFormatPkg::*, outWordPkg::*;
#(
	parameter int FifoDepth = 8192,
	parameter int CountWidth = 14,
	parameter int BlockCountWidth = 8
)
(
	input  logic                       CLK,
	input  logic                       RSTb,
	input  logic                       enable,
	input  logic                       clear,
	input  logic                       mode64,
	input  logic                       evbEmpty,
	input  eventWord_u                 evbData,
	input  logic                       userRe,
	output logic                       evbRead,
	output outWord_t                   userData,
	output fiberWord_t                 fiberData,
	output logic                       fifoEmpty,
	output logic                       fifoFull,
	output logic                       fifoFullSeen,
	output logic [CountWidth-1:0]      fifoCount,
	output logic [BlockCountWidth-1:0] blockCount
);

	logic fifoWrite;
	logic acceptedWrite;
	logic acceptedRead;
	outWord_t packedWord;
	outWord_t headWord;
	fiberWord_t headLow;

	// Only words that really enter or leave the FIFO count for blocks
	assign acceptedWrite = fifoWrite && !fifoFull;
	assign acceptedRead = userRe && !fifoEmpty;

	assign headLow = headWord[FiberWidth-1:0];
	assign fiberData = {headLow[15:0], headLow[31:16]};	// Half-word swapped

	eventPairPacker packer
	(
		.CLK        (CLK),
		.RSTb       (RSTb),
		.enable     (enable),
		.clear      (clear),
		.mode64     (mode64),
		.evbEmpty   (evbEmpty),
		.evbData    (evbData),
		.fifoFull   (fifoFull),
		.evbRead    (evbRead),
		.fifoWrite  (fifoWrite),
		.packedWord (packedWord)
	);

	outputFifo #(
		.FifoDepth  (FifoDepth),
		.CountWidth (CountWidth)
	) wordFifo
	(
		.CLK       (CLK),
		.RSTb      (RSTb),
		.clear     (clear),
		.write     (fifoWrite),
		.writeWord (packedWord),
		.read      (userRe),
		.headWord  (headWord),
		.readWord  (userData),
		.empty     (fifoEmpty),
		.full      (fifoFull),
		.fullSeen  (fifoFullSeen),
		.count     (fifoCount)
	);

	blockTracker #(
		.BlockCountWidth (BlockCountWidth)
	) tracker
	(
		.CLK        (CLK),
		.RSTb       (RSTb),
		.clear      (clear),
		.write      (acceptedWrite),
		.writeWord  (packedWord),
		.read       (acceptedRead),
		.headWord   (headWord),
		.blockCount (blockCount)
	);

endmodule

// ==== source/eventPairPacker.sv ====
// Event pair packer, pops builder events and packs them into 64-bit output words
`timescale 1ns/1ps

module eventPairPacker
	import evbFormatPkg::*, outWordPkg::*;
(
	input  logic       CLK,
	input  logic       RSTb,
	input  logic       enable,
	input  logic       clear,
	input  logic       mode64,
	input  logic       evbEmpty,
	input  eventWord_u evbData,
	input  logic       fifoFull,
	output logic       evbRead,
	output logic       fifoWrite,
	output outWord_t   packedWord
);

	localparam logic ReadIdle = 1'b0;
	localparam logic ReadActive = 1'b1;

	logic readState;
	logic oddEvent;	// Next event goes to the lower half
	logic loadUpper;
	logic loadLower;
	logic lowerEob;
	eventWord_u upperReg;
	eventWord_u lowerReg;

	assign evbRead = (readState == ReadActive) && !evbEmpty;

	// 32-bit mode copies every event into both halves
	assign loadUpper = evbRead && (!mode64 || !oddEvent);
	assign loadLower = evbRead && (!mode64 || oddEvent);

	assign lowerEob = (lowerReg.fields.tag == EndOfBlockTag);

	assign packedWord = '{
		padUpper:   '0,
		upperEvent: upperReg,
		padLower:   '0,
		lowerEvent: lowerReg
	};

	// Read machine
	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (RSTb == 1'b0)
			readState <= ReadIdle;
		else
		begin
			case (readState)
				ReadIdle:
				begin
					if (enable && !evbEmpty && !fifoFull)
						readState <= ReadActive;
				end
				ReadActive:
				begin
					if (!enable || evbEmpty || fifoFull)
						readState <= ReadIdle;
				end
				default: readState <= ReadIdle;
			endcase
		end
	end

	// Parity machine, restarts at even on disable, clear or end of block
	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (RSTb == 1'b0)
			oddEvent <= 1'b0;
		else
		begin
			if (clear || !enable)
				oddEvent <= 1'b0;
			else if (fifoWrite && lowerEob)
				oddEvent <= evbRead && mode64;	// A pop on this edge opens a new pair
			else if (evbRead && mode64)
				oddEvent <= !oddEvent;
		end
	end

	// Event half registers
	always_ff @(posedge CLK)
	begin
		if (loadUpper)
			upperReg <= evbData;
		if (loadLower)
			lowerReg <= evbData;
	end

	// Word is complete once the lower half is loaded
	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (RSTb == 1'b0)
			fifoWrite <= 1'b0;
		else
			fifoWrite <= loadLower;
	end

endmodule

// ==== source/outWordPkg.sv ====
// Output word package, 64-bit FIFO word with two event slots and the fiber word
package outWordPkg;

	import evbFormatPkg::*;

	localparam int PadWidth = 8;
	localparam int FiberWidth = 32;

	// Two zero-padded event slots, upper slot holds the first event of a pair
	typedef struct packed
	{
		logic [PadWidth-1:0] padUpper;
		eventWord_u upperEvent;
		logic [PadWidth-1:0] padLower;
		eventWord_u lowerEvent;
	} outWord_t;

	// Word presented on the fiber port
	typedef logic [FiberWidth-1:0] fiberWord_t;

endpackage

// ==== source/outputFifo.sv ====
// Output FIFO, show-ahead circular buffer of 64-bit words with user read register
`timescale 1ns/1ps

module outputFifo
	import outWordPkg::*;
#(
	parameter int FifoDepth = 8192,
	parameter int CountWidth = 14
)
(
	input  logic                  CLK,
	input  logic                  RSTb,
	input  logic                  clear,
	input  logic                  write,
	input  outWord_t              writeWord,
	input  logic                  read,
	output outWord_t              headWord,
	output outWord_t              readWord,
	output logic                  empty,
	output logic                  full,
	output logic                  fullSeen,
	output logic [CountWidth-1:0] count
);

	localparam int AddrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
	localparam logic [AddrWidth-1:0] LastAddr = AddrWidth'(FifoDepth - 1);
	localparam logic [CountWidth-1:0] FullCount = CountWidth'(FifoDepth);

	outWord_t memory [FifoDepth];
	logic [AddrWidth-1:0] writePtr;
	logic [AddrWidth-1:0] readPtr;
	logic doWrite;
	logic doRead;

	assign full = (count == FullCount);
	assign empty = (count == '0);

	assign doWrite = write && !full;	// Writes while full are dropped
	assign doRead = read && !empty;

	assign headWord = memory[readPtr];	// Show-ahead head

	always_ff @(posedge CLK)
	begin
		if (doWrite)
			memory[writePtr] <= writeWord;
	end

	// Pointers and occupancy
	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (RSTb == 1'b0)
		begin
			writePtr <= '0;
			readPtr <= '0;
			count <= '0;
		end
		else if (clear)
		begin
			writePtr <= '0;
			readPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWrite)
				writePtr <= (writePtr == LastAddr) ? '0 : writePtr + 1'b1;
			if (doRead)
				readPtr <= (readPtr == LastAddr) ? '0 : readPtr + 1'b1;
			case ({doWrite, doRead})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Sticky full flag
	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (RSTb == 1'b0)
			fullSeen <= 1'b0;
		else if (clear)
			fullSeen <= 1'b0;
		else if (full)
			fullSeen <= 1'b1;
	end

	always_ff @(posedge CLK)
	begin
		if (doRead)
			readWord <= headWord;	// User data port
	end

endmodule

// ==== tb.f ====
+incdir+test
source/evbFormatPkg.sv
source/outWordPkg.sv
source/eventPairPacker.sv
source/outputFifo.sv
source/blockTracker.sv
source/evbReadout.sv
test/tbEvbReadout.sv

// ==== test/tbTasks.svh ====
// Testbench tasks, typed compares, source helpers and the directed readout tests

task automatic valueMismatch(string name, logic [63:0] got, logic [63:0] expected);
	errorCount++;
	$display("CHECK FAILED %s: got %0h, expected %0h", name, got, expected);
endtask

task automatic reportError(string what);
	errorCount++;
	$display("ERROR: %s", what);
endtask

task automatic compareWord(string name, outWord_t got, outWord_t expected);
	checkCount++;
	if (got !== expected)
		valueMismatch(name, got, expected);
endtask

task automatic compareFiber(string name, fiberWord_t got, fiberWord_t expected);
	checkCount++;
	if (got !== expected)
		valueMismatch(name, 64'(got), 64'(expected));
endtask

task automatic compareCount(string name, logic [CountWidth-1:0] got, int expected);
	checkCount++;
	if (got !== CountWidth'(expected))
		valueMismatch(name, 64'(got), 64'(expected));
endtask

task automatic compareFlag(string name, logic got, logic expected);
	checkCount++;
	if (got !== expected)
		valueMismatch(name, 64'(got), 64'(expected));
endtask

// Random payload, tag kept off the end-of-block code
function automatic eventWord_u randomEvent();
	eventWord_u ev;
	ev.raw = 24'($random(seed));
	if (ev.fields.tag == EndOfBlockTag)
		ev.fields.tag = 4'h1;
	return ev;
endfunction

function automatic outWord_t pairWord(eventWord_u upper, eventWord_u lower);
	return '{padUpper: 8'h00, upperEvent: upper, padLower: 8'h00, lowerEvent: lower};
endfunction

// Lower 32 bits with the 16-bit halves swapped
function automatic fiberWord_t swapFiber(outWord_t word);
	return {word.lowerEvent.raw[15:0], word.padLower, word.lowerEvent.raw[23:16]};
endfunction

task automatic pushEvent(eventWord_u ev);
	@(posedge CLK);
	evQueue.push_back(ev);	// Shown by the source model at the next falling edge
	@(negedge CLK);
endtask

task automatic popAndCheck(outWord_t expected);
	while (fifoEmpty)
		@(negedge CLK);
	compareFiber("fiberData", fiberData, swapFiber(expected));
	userRe = 1'b1;
	@(negedge CLK);
	userRe = 1'b0;
	compareWord("userData", userData, expected);
endtask

task automatic runMode32Stream();
	eventWord_u events [8];
	mode64 = 1'b0;
	enable = 1'b1;
	for (int i = 0; i < 8; i++)
	begin
		events[i] = randomEvent();
		pushEvent(events[i]);
	end
	for (int i = 0; i < 8; i++)
		popAndCheck(pairWord(events[i], events[i]));
endtask

task automatic pairMode64Events();
	eventWord_u events [8];
	mode64 = 1'b1;
	enable = 1'b1;
	for (int i = 0; i < 8; i++)
	begin
		events[i] = randomEvent();
		pushEvent(events[i]);
	end
	for (int i = 0; i < 4; i++)
		popAndCheck(pairWord(events[2*i], events[2*i+1]));	// First of pair on top
endtask

task automatic restartParity();
	eventWord_u events [3];
	for (int i = 0; i < 3; i++)
		events[i] = randomEvent();
	mode64 = 1'b1;
	enable = 1'b1;
	pushEvent(events[0]);
	while (evQueue.size() != 0)
		@(posedge CLK);
	@(negedge CLK);
	enable = 1'b0;
	pushEvent(events[1]);	// Waits in the source while disabled
	repeat (2) @(negedge CLK);
	if (evbRead || evQueue.size() == 0)
		reportError("evbRead active while enable was low");
	enable = 1'b1;
	pushEvent(events[2]);
	popAndCheck(pairWord(events[1], events[2]));
	compareCount("fifoCount", fifoCount, 0);	// Lone first event never written
endtask

task automatic countBlocks();
	eventWord_u events [6];
	bit isEnd [6];
	int expectedBlocks;
	isEnd = '{0, 1, 0, 0, 1, 1};	// Blocks of two, three and one events
	expectedBlocks = 3;
	mode64 = 1'b0;
	enable = 1'b1;
	for (int i = 0; i < 6; i++)
	begin
		events[i] = randomEvent();
		if (isEnd[i])
			events[i].fields.tag = EndOfBlockTag;
		pushEvent(events[i]);
	end
	while (fifoCount != 6)
		@(negedge CLK);
	repeat (2) @(negedge CLK);	// Count trails the write by two cycles
	compareCount("blockCount", CountWidth'(blockCount), expectedBlocks);
	for (int i = 0; i < 6; i++)
	begin
		popAndCheck(pairWord(events[i], events[i]));
		if (isEnd[i])
			expectedBlocks--;
		@(negedge CLK);
		compareCount("blockCount", CountWidth'(blockCount), expectedBlocks);
	end
endtask

task automatic fillAndClear();
	eventWord_u events [24];
	mode64 = 1'b0;
	enable = 1'b1;
	for (int i = 0; i < 24; i++)
	begin
		events[i] = randomEvent();
		if (i == 17 || i == 23)
			events[i].fields.tag = EndOfBlockTag;	// One lost block end, one kept
		pushEvent(events[i]);
	end
	while (!fifoFull)
		@(negedge CLK);
	repeat (2) @(negedge CLK);	// Packer drops out one edge after full
	compareFlag("fifoFull", fifoFull, 1'b1);
	compareFlag("fifoFullSeen", fifoFullSeen, 1'b1);
	compareCount("fifoCount", fifoCount, FifoDepth);
	if (evbRead || evQueue.size() == 0)
		reportError("evbRead did not stop while events were still waiting");
	enable = 1'b0;
	for (int i = 0; i < FifoDepth; i++)
		popAndCheck(pairWord(events[i], events[i]));
	// Events 16 and 17 went into a full FIFO and are gone
	enable = 1'b1;
	while (fifoCount != 6)
		@(negedge CLK);
	repeat (2) @(negedge CLK);
	compareFiber("fiberData", fiberData, swapFiber(pairWord(events[18], events[18])));
	compareCount("blockCount", CountWidth'(blockCount), 1);
	clear = 1'b1;
	@(negedge CLK);
	clear = 1'b0;
	compareFlag("fifoFullSeen", fifoFullSeen, 1'b0);
	compareFlag("fifoEmpty", fifoEmpty, 1'b1);
	compareCount("fifoCount", fifoCount, 0);
	compareCount("blockCount", CountWidth'(blockCount), 0);
endtask

// ==== test/tbEvbReadout.sv ====
// Testbench for the event buffer readout, with event builder model and watchdog
`timescale 1ns/1ps

module tbEvbReadout
	import evbFormatPkg::*, outWordPkg::*;
();

	localparam int FifoDepth = 16;
	localparam int CountWidth = 14;
	localparam int BlockCountWidth = 8;
	localparam int TotalEvents = 49;	// Events over all five tests
	localparam int TimeoutCycles = TotalEvents * 4 + 200;

	logic CLK;
	logic RSTb;
	logic enable;
	logic clear;
	logic mode64;
	logic evbEmpty;
	eventWord_u evbData;
	logic userRe;
	logic evbRead;
	outWord_t userData;
	fiberWord_t fiberData;
	logic fifoEmpty;
	logic fifoFull;
	logic fifoFullSeen;
	logic [CountWidth-1:0] fifoCount;
	logic [BlockCountWidth-1:0] blockCount;

	eventWord_u evQueue [$];	// Contents of the builder FIFO
	logic popSeen;
	int seed = 32'h65cf_622d;
	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;

	evbReadout #(
		.FifoDepth       (FifoDepth),
		.CountWidth      (CountWidth),
		.BlockCountWidth (BlockCountWidth)
	) dut
	(
		.CLK          (CLK),
		.RSTb         (RSTb),
		.enable       (enable),
		.clear        (clear),
		.mode64       (mode64),
		.evbEmpty     (evbEmpty),
		.evbData      (evbData),
		.userRe       (userRe),
		.evbRead      (evbRead),
		.userData     (userData),
		.fiberData    (fiberData),
		.fifoEmpty    (fifoEmpty),
		.fifoFull     (fifoFull),
		.fifoFullSeen (fifoFullSeen),
		.fifoCount    (fifoCount),
		.blockCount   (blockCount)
	);

	`include "tbTasks.svh"

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Pop strobe as the builder FIFO sees it on the rising edge
	always @(posedge CLK or negedge RSTb)
	begin
		if (RSTb == 1'b0)
			popSeen <= 1'b0;
		else
			popSeen <= evbRead;
	end

	// First-word-fall-through source, head shown after each falling edge
	initial
	begin
		evbEmpty = 1'b1;
		evbData = '0;
		forever
		begin
			@(negedge CLK);
			if (popSeen && evQueue.size() > 0)
				void'(evQueue.pop_front());
			evbEmpty = (evQueue.size() == 0);
			evbData = (evQueue.size() > 0) ? evQueue[0] : '0;
		end
	end

	always @(posedge CLK)
	begin
		cycleCount++;
		if (cycleCount > TimeoutCycles)
		begin
			$display("Timeout, run stopped after %0d cycles", cycleCount);
			$display("Checks: %0d, errors: %0d", checkCount, errorCount + 1);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial
	begin
		RSTb = 1'b0;
		enable = 1'b0;
		clear = 1'b0;
		mode64 = 1'b0;
		userRe = 1'b0;
		repeat (10) @(negedge CLK);
		RSTb = 1'b1;
		@(negedge CLK);
		runMode32Stream();
		pairMode64Events();
		restartParity();
		countBlocks();
		fillAndClear();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
